//--- Makefile
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/Vtb_cpu_datapath: flist.f $(wildcard *.sv)
	verilator --binary --timing --assert --top-module tb_cpu_datapath -f flist.f

run: obj_dir/Vtb_cpu_datapath
	./obj_dir/Vtb_cpu_datapath > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

lint:
	verilator --lint-only --timing --assert --top-module tb_cpu_datapath -f flist.f

clean:
	rm -rf obj_dir $(LOG)

//--- cpu_datapath.sv
`timescale 1ns/100ps

module cpu_datapath
(
	input logic clk,
	input logic rst,
	output lc3b_isa_pkg::lc3b_word mem_addr1,
	output logic mem_read1,
	input lc3b_isa_pkg::lc3b_word mem_rdata1,
	output lc3b_isa_pkg::lc3b_word mem_addr2,
	output logic mem_read2,
	output logic mem_write2,
	input lc3b_isa_pkg::lc3b_word mem_rdata2,
	output lc3b_isa_pkg::lc3b_word mem_wdata2
);

	lc3b_pipe_pkg::if_id_t if_id;
	lc3b_pipe_pkg::id_ex_t id_ex;
	lc3b_pipe_pkg::ex_mem_t ex_mem;
	lc3b_pipe_pkg::mem_wb_t mem_wb;

	// Writeback feedback.
	logic reg_we;
	lc3b_isa_pkg::lc3b_reg reg_waddr;
	lc3b_isa_pkg::lc3b_word reg_wdata;
	logic branch_enable;
	lc3b_isa_pkg::lc3b_word br_target;

	instruction_fetch instruction_fetch_i (
		.clk(clk),
		.rst(rst),
		.branch_enable(branch_enable),
		.br_target(br_target),
		.mem_rdata1(mem_rdata1),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.if_id(if_id)
	);

	instruction_decode instruction_decode_i (
		.clk(clk),
		.rst(rst),
		.if_id(if_id),
		.reg_we(reg_we),
		.reg_waddr(reg_waddr),
		.reg_wdata(reg_wdata),
		.id_ex(id_ex)
	);

	execution_module execution_module_i (
		.clk(clk),
		.rst(rst),
		.id_ex(id_ex),
		.ex_mem(ex_mem)
	);

	memory_module memory_module_i (
		.clk(clk),
		.rst(rst),
		.ex_mem(ex_mem),
		.mem_rdata2(mem_rdata2),
		.mem_addr2(mem_addr2),
		.mem_wdata2(mem_wdata2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_wb(mem_wb)
	);

	writeback_module writeback_module_i (
		.clk(clk),
		.rst(rst),
		.mem_wb(mem_wb),
		.reg_we(reg_we),
		.reg_waddr(reg_waddr),
		.reg_wdata(reg_wdata),
		.branch_enable(branch_enable),
		.br_target(br_target)
	);

endmodule : cpu_datapath

//--- cpu_datapath_props.sv
`timescale 1ns/100ps

module cpu_datapath_props
(
	input logic clk,
	input logic rst,
	input lc3b_isa_pkg::lc3b_word mem_addr1,
	input logic mem_read2,
	input logic mem_write2
);

	a_strobe_excl: assert property (@(posedge clk) disable iff (rst)
		!(mem_read2 && mem_write2))
		else $error("mem_read2 and mem_write2 high in the same cycle");

	// Strobes settle one edge into reset.
	a_reset_quiet: assert property (@(posedge clk)
		rst && $past(rst) |-> !mem_read2 && !mem_write2)
		else $error("data port strobe high during reset");

	a_pc_even: assert property (@(posedge clk) disable iff (rst) !mem_addr1[0])
		else $error("odd instruction address on mem_addr1");

endmodule : cpu_datapath_props

bind cpu_datapath cpu_datapath_props cpu_datapath_props_i (
	.clk(clk),
	.rst(rst),
	.mem_addr1(mem_addr1),
	.mem_read2(mem_read2),
	.mem_write2(mem_write2)
);

//--- execution_module.sv
`timescale 1ns/100ps

module execution_module
(
	input logic clk,
	input logic rst,
	input lc3b_pipe_pkg::id_ex_t id_ex,
	output lc3b_pipe_pkg::ex_mem_t ex_mem
);

	lc3b_isa_pkg::lc3b_word opnd_b;
	lc3b_isa_pkg::lc3b_word alu_out;
	lc3b_isa_pkg::lc3b_word offset_x2;
	lc3b_pipe_pkg::ex_mem_t ex_mem_d;

	assign offset_x2 = {id_ex.offset[14:0], 1'b0};

	always_comb begin
		if (id_ex.control.mem_read || id_ex.control.mem_write) begin
			opnd_b = offset_x2; // Base plus offset6 for LDR and STR.
		end else if (id_ex.control.use_imm) begin
			opnd_b = id_ex.imm;
		end else begin
			opnd_b = id_ex.sr2_val;
		end
	end

	always_comb begin
		case (id_ex.control.alu_op)
			lc3b_pipe_pkg::alu_add: alu_out = id_ex.sr1_val + opnd_b;
			lc3b_pipe_pkg::alu_and: alu_out = id_ex.sr1_val & opnd_b;
			lc3b_pipe_pkg::alu_not: alu_out = ~id_ex.sr1_val;
			default: alu_out = id_ex.sr1_val;
		endcase
	end

	always_comb begin
		ex_mem_d.valid = id_ex.valid;
		ex_mem_d.control = id_ex.control;
		ex_mem_d.pc_next = id_ex.pc_next;
		ex_mem_d.alu_result = alu_out;
		ex_mem_d.store_data = id_ex.sr2_val;
		ex_mem_d.br_target = id_ex.pc_next + offset_x2; // Branch adder.
	end

	always_ff @(posedge clk) begin
		ex_mem <= ex_mem_d;
		if (rst) begin
			ex_mem.valid <= 1'b0;
		end
	end

endmodule : execution_module

//--- flist.f
lc3b_isa_pkg.sv
lc3b_pipe_pkg.sv
instruction_fetch.sv
instruction_decode.sv
execution_module.sv
memory_module.sv
writeback_module.sv
cpu_datapath.sv
cpu_datapath_props.sv
tb_cpu_datapath.sv

//--- instruction_decode.sv
`timescale 1ns/100ps

module instruction_decode
(
	input logic clk,
	input logic rst,
	input lc3b_pipe_pkg::if_id_t if_id,
	input logic reg_we,
	input lc3b_isa_pkg::lc3b_reg reg_waddr,
	input lc3b_isa_pkg::lc3b_word reg_wdata,
	output lc3b_pipe_pkg::id_ex_t id_ex
);

	lc3b_isa_pkg::lc3b_word regs [8];
	lc3b_isa_pkg::lc3b_word instr;
	lc3b_isa_pkg::lc3b_opcode opcode;
	lc3b_isa_pkg::lc3b_reg dr;
	lc3b_isa_pkg::lc3b_reg sr1;
	lc3b_isa_pkg::lc3b_reg sr2;
	lc3b_pipe_pkg::lc3b_control ctrl;
	lc3b_pipe_pkg::id_ex_t id_ex_d;

	// Same-cycle writeback is visible to the read.
	function automatic lc3b_isa_pkg::lc3b_word rf_read(input lc3b_isa_pkg::lc3b_reg addr);
		lc3b_isa_pkg::lc3b_word val;
		val = regs[addr];
		if (reg_we && reg_waddr == addr) begin
			val = reg_wdata;
		end
		return val;
	endfunction

	always_ff @(posedge clk) begin
		if (reg_we) begin
			regs[reg_waddr] <= reg_wdata;
		end
	end

	assign instr = if_id.valid ? if_id.instr : lc3b_isa_pkg::nop_instr;
	assign opcode = lc3b_isa_pkg::lc3b_opcode'(instr[lc3b_isa_pkg::op_lsb +: 4]);
	assign dr = instr[lc3b_isa_pkg::dr_lsb +: 3];
	assign sr1 = instr[lc3b_isa_pkg::sr1_lsb +: 3];
	// STR reads its source from the DR field.
	assign sr2 = (opcode == lc3b_isa_pkg::op_str) ? dr : instr[lc3b_isa_pkg::sr2_lsb +: 3];

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = lc3b_pipe_pkg::alu_pass;
		ctrl.dest = dr;
		case (opcode)
			lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and: begin
				ctrl.alu_op = (opcode == lc3b_isa_pkg::op_add) ?
					lc3b_pipe_pkg::alu_add : lc3b_pipe_pkg::alu_and;
				ctrl.use_imm = instr[lc3b_isa_pkg::imm_flag];
				ctrl.reg_load = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			lc3b_isa_pkg::op_not: begin
				ctrl.alu_op = lc3b_pipe_pkg::alu_not;
				ctrl.reg_load = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			lc3b_isa_pkg::op_ldr: begin
				ctrl.alu_op = lc3b_pipe_pkg::alu_add;
				ctrl.mem_read = 1'b1;
				ctrl.reg_load = 1'b1;
				ctrl.wb_from_mem = 1'b1;
				ctrl.set_cc = 1'b1;
			end
			lc3b_isa_pkg::op_str: begin
				ctrl.alu_op = lc3b_pipe_pkg::alu_add;
				ctrl.mem_write = 1'b1;
			end
			lc3b_isa_pkg::op_br: begin
				ctrl.is_branch = 1'b1;
				ctrl.nzp = dr;
			end
			default: begin
				ctrl.nzp = 3'b000; // Unsupported opcodes retire as NOPs.
			end
		endcase
	end

	always_comb begin
		id_ex_d.valid = if_id.valid;
		id_ex_d.control = ctrl;
		id_ex_d.pc_next = if_id.pc_next;
		id_ex_d.sr1_val = rf_read(sr1);
		id_ex_d.sr2_val = rf_read(sr2);
		id_ex_d.imm = {{11{instr[4]}}, instr[4:0]};
		if (opcode == lc3b_isa_pkg::op_br) begin
			id_ex_d.offset = {{7{instr[8]}}, instr[8:0]};
		end else begin
			id_ex_d.offset = {{10{instr[5]}}, instr[5:0]};
		end
	end

	always_ff @(posedge clk) begin
		id_ex <= id_ex_d;
		if (rst) begin
			id_ex.valid <= 1'b0;
		end
	end

endmodule : instruction_decode

//--- instruction_fetch.sv
`timescale 1ns/100ps

module instruction_fetch
(
	input logic clk,
	input logic rst,
	input logic branch_enable,
	input lc3b_isa_pkg::lc3b_word br_target,
	input lc3b_isa_pkg::lc3b_word mem_rdata1,
	output lc3b_isa_pkg::lc3b_word mem_addr1,
	output logic mem_read1,
	output lc3b_pipe_pkg::if_id_t if_id
);

	lc3b_isa_pkg::lc3b_word pc;
	lc3b_isa_pkg::lc3b_word pc_plus;

	assign pc_plus = pc + lc3b_isa_pkg::pc_step;

	// Branch resolved in writeback overrides the sequential PC.
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= lc3b_isa_pkg::pc_reset;
		end else if (branch_enable) begin
			pc <= br_target;
		end else begin
			pc <= pc_plus;
		end
	end

	assign mem_addr1 = pc;
	assign mem_read1 = !rst; // Fetch every cycle out of reset.

	always_ff @(posedge clk) begin
		if_id.instr <= mem_rdata1;
		if_id.pc_next <= pc_plus;
		if (rst) begin
			if_id.valid <= 1'b0;
		end else begin
			if_id.valid <= 1'b1;
		end
	end

endmodule : instruction_fetch

//--- lc3b_isa_pkg.sv
package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;
	typedef logic [2:0] lc3b_nzp;

	// LC-3b encodings for the supported subset.
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001
	} lc3b_opcode;

	localparam lc3b_word pc_reset = 16'h0000;
	localparam lc3b_word pc_step = 16'd2; // Byte distance between instructions.
	localparam lc3b_word nop_instr = 16'h0000; // BR with nzp 000.

	// Low bit positions of the instruction fields.
	localparam int op_lsb = 12;
	localparam int dr_lsb = 9; // Also SR of STR and nzp of BR.
	localparam int sr1_lsb = 6;
	localparam int sr2_lsb = 0;
	localparam int imm_flag = 5; // Immediate form of ADD and AND.

endpackage : lc3b_isa_pkg

//--- lc3b_pipe_pkg.sv
package lc3b_pipe_pkg;

	typedef enum logic [1:0] {
		alu_add,
		alu_and,
		alu_not,
		alu_pass
	} lc3b_alu_op;

	typedef struct packed {
		lc3b_alu_op alu_op;
		logic use_imm;
		logic mem_read;
		logic mem_write;
		logic reg_load;
		logic wb_from_mem;
		logic set_cc;
		logic is_branch;
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_isa_pkg::lc3b_nzp nzp; // Branch mask.
	} lc3b_control;

	typedef struct packed {
		logic valid;
		lc3b_isa_pkg::lc3b_word instr;
		lc3b_isa_pkg::lc3b_word pc_next;
	} if_id_t;

	typedef struct packed {
		logic valid;
		lc3b_control control;
		lc3b_isa_pkg::lc3b_word pc_next;
		lc3b_isa_pkg::lc3b_word sr1_val;
		lc3b_isa_pkg::lc3b_word sr2_val;
		lc3b_isa_pkg::lc3b_word imm;
		lc3b_isa_pkg::lc3b_word offset; // Word offset, not yet doubled.
	} id_ex_t;

	typedef struct packed {
		logic valid;
		lc3b_control control;
		lc3b_isa_pkg::lc3b_word pc_next;
		lc3b_isa_pkg::lc3b_word alu_result;
		lc3b_isa_pkg::lc3b_word store_data;
		lc3b_isa_pkg::lc3b_word br_target;
	} ex_mem_t;

	typedef struct packed {
		logic valid;
		lc3b_control control;
		lc3b_isa_pkg::lc3b_word alu_result;
		lc3b_isa_pkg::lc3b_word load_data;
		lc3b_isa_pkg::lc3b_word br_target;
	} mem_wb_t;

endpackage : lc3b_pipe_pkg

//--- memory_module.sv
`timescale 1ns/100ps

module memory_module
(
	input logic clk,
	input logic rst,
	input lc3b_pipe_pkg::ex_mem_t ex_mem,
	input lc3b_isa_pkg::lc3b_word mem_rdata2,
	output lc3b_isa_pkg::lc3b_word mem_addr2,
	output lc3b_isa_pkg::lc3b_word mem_wdata2,
	output logic mem_read2,
	output logic mem_write2,
	output lc3b_pipe_pkg::mem_wb_t mem_wb
);

	lc3b_pipe_pkg::mem_wb_t mem_wb_d;

	// Strobes only from an occupied slot.
	assign mem_read2 = ex_mem.valid && ex_mem.control.mem_read;
	assign mem_write2 = ex_mem.valid && ex_mem.control.mem_write;
	assign mem_addr2 = ex_mem.alu_result;
	assign mem_wdata2 = ex_mem.store_data;

	always_comb begin
		mem_wb_d.valid = ex_mem.valid;
		mem_wb_d.control = ex_mem.control;
		mem_wb_d.alu_result = ex_mem.alu_result;
		mem_wb_d.load_data = mem_rdata2; // Data port answers in the same cycle.
		mem_wb_d.br_target = ex_mem.br_target;
	end

	always_ff @(posedge clk) begin
		mem_wb <= mem_wb_d;
		if (rst) begin
			mem_wb.valid <= 1'b0;
		end
	end

endmodule : memory_module

//--- tb_cpu_datapath.sv
`timescale 1ns/100ps

module tb_cpu_datapath;

	localparam int mem_words = 32768;
	localparam int prog_len = 64; // Real instructions, each padded by four NOPs.
	localparam int timeout_cycles = 2000;

	logic clk = 1'b0;
	logic rst = 1'b1;
	lc3b_isa_pkg::lc3b_word mem_addr1;
	logic mem_read1;
	lc3b_isa_pkg::lc3b_word mem_rdata1;
	lc3b_isa_pkg::lc3b_word mem_addr2;
	logic mem_read2;
	logic mem_write2;
	lc3b_isa_pkg::lc3b_word mem_rdata2;
	lc3b_isa_pkg::lc3b_word mem_wdata2;

	lc3b_isa_pkg::lc3b_word imem [mem_words];
	lc3b_isa_pkg::lc3b_word dmem [mem_words];
	lc3b_isa_pkg::lc3b_word model_mem [mem_words];
	lc3b_isa_pkg::lc3b_word prog [prog_len];
	lc3b_isa_pkg::lc3b_word exp_fetch [$];
	lc3b_isa_pkg::lc3b_word exp_load [$];
	lc3b_isa_pkg::lc3b_word exp_st_addr [$];
	lc3b_isa_pkg::lc3b_word exp_st_data [$];
	integer seed = 32'he93;
	int fetch_seen = 0;
	int loads_seen = 0;
	int stores_seen = 0;
	bit first_seen = 1'b0;
	int cycles;

	cpu_datapath cpu_datapath_i (
		.clk(clk),
		.rst(rst),
		.mem_addr1(mem_addr1),
		.mem_read1(mem_read1),
		.mem_rdata1(mem_rdata1),
		.mem_addr2(mem_addr2),
		.mem_read2(mem_read2),
		.mem_write2(mem_write2),
		.mem_rdata2(mem_rdata2),
		.mem_wdata2(mem_wdata2)
	);

	always #4 clk = ~clk;

	assign mem_rdata1 = imem[mem_addr1[15:1]]; // Both ports answer in the same cycle.
	assign mem_rdata2 = dmem[mem_addr2[15:1]];

	always @(posedge clk) begin
		if (mem_write2) begin
			dmem[mem_addr2[15:1]] <= mem_wdata2;
		end
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic check(input string name, input lc3b_isa_pkg::lc3b_word got,
		input lc3b_isa_pkg::lc3b_word exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			fail_run("value mismatch on a DUT port");
		end
	endtask

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % n);
	endfunction

	function automatic lc3b_isa_pkg::lc3b_nzp cc_of(input lc3b_isa_pkg::lc3b_word v);
		return v[15] ? 3'b100 : ((v == 16'h0000) ? 3'b010 : 3'b001);
	endfunction

	task automatic gen_program();
		lc3b_isa_pkg::lc3b_reg dr;
		lc3b_isa_pkg::lc3b_reg sr1;
		lc3b_isa_pkg::lc3b_reg sr2;
		logic [5:0] off6;
		int span;
		prog[0] = {lc3b_isa_pkg::op_and, 3'd0, 3'd0, 1'b1, 5'd0}; // Clears R0 even from X.
		for (int k = 1; k <= 8; k++) begin
			prog[k] = {lc3b_isa_pkg::op_ldr, 3'(k), 3'd0, 6'(rand_below(64))}; // R0 last.
		end
		for (int k = 9; k < prog_len - 1; k++) begin
			dr = 3'(rand_below(8));
			sr1 = 3'(rand_below(8));
			sr2 = 3'(rand_below(8));
			off6 = 6'(rand_below(64));
			case (rand_below(10))
				0: prog[k] = {lc3b_isa_pkg::op_add, dr, sr1, 3'b000, sr2};
				1: prog[k] = {lc3b_isa_pkg::op_add, dr, sr1, 1'b1, off6[4:0]};
				2: prog[k] = {lc3b_isa_pkg::op_and, dr, sr1, 3'b000, sr2};
				3: prog[k] = {lc3b_isa_pkg::op_and, dr, sr1, 1'b1, off6[4:0]};
				4: prog[k] = {lc3b_isa_pkg::op_not, dr, sr1, 6'h3f};
				5, 6: prog[k] = {lc3b_isa_pkg::op_ldr, dr, sr1, off6};
				7, 8: prog[k] = {lc3b_isa_pkg::op_str, dr, sr1, off6};
				default: begin
					span = prog_len - 1 - k;
					if (span > 51) begin
						span = 51;
					end
					// Forward by whole slots of five words.
					prog[k] = {lc3b_isa_pkg::op_br, 3'(1 + rand_below(7)),
						9'(5 * (1 + rand_below(span)) - 1)};
				end
			endcase
		end
		prog[prog_len - 1] = {lc3b_isa_pkg::op_br, 3'b111, 9'h1ff}; // Spins on itself.
		for (int k = 0; k < prog_len; k++) begin
			imem[5 * k] = prog[k];
		end
	endtask

	task automatic run_model();
		lc3b_isa_pkg::lc3b_word regs [8];
		lc3b_isa_pkg::lc3b_word w;
		lc3b_isa_pkg::lc3b_word opnd;
		lc3b_isa_pkg::lc3b_word res;
		lc3b_isa_pkg::lc3b_word addr;
		lc3b_isa_pkg::lc3b_nzp cc;
		int k;
		int next;
		bit done;
		k = 0;
		cc = 3'b000;
		done = 1'b0;
		foreach (regs[i]) begin
			regs[i] = '0;
		end
		while (!done) begin
			w = prog[k];
			exp_fetch.push_back(16'(10 * k));
			next = k + 1;
			opnd = w[5] ? {{11{w[4]}}, w[4:0]} : regs[w[2:0]];
			addr = regs[w[8:6]] + {{9{w[5]}}, w[5:0], 1'b0};
			res = '0;
			case (w[15:12])
				lc3b_isa_pkg::op_add: res = regs[w[8:6]] + opnd;
				lc3b_isa_pkg::op_and: res = regs[w[8:6]] & opnd;
				lc3b_isa_pkg::op_not: res = ~regs[w[8:6]];
				lc3b_isa_pkg::op_ldr: begin
					res = model_mem[addr[15:1]];
					exp_load.push_back(addr);
				end
				lc3b_isa_pkg::op_str: begin
					model_mem[addr[15:1]] = regs[w[11:9]];
					exp_st_addr.push_back(addr);
					exp_st_data.push_back(regs[w[11:9]]);
				end
				default: begin
					if ((w[11:9] & cc) != 3'b000) begin
						next = (10 * k + 2 + 2 * int'($signed(w[8:0]))) / 10;
					end
				end
			endcase
			if (w[15:12] != lc3b_isa_pkg::op_str && w[15:12] != lc3b_isa_pkg::op_br) begin
				regs[w[11:9]] = res;
				cc = cc_of(res);
			end
			done = (k == prog_len - 1);
			k = next;
		end
	endtask

	// Port monitor against the model's expected traffic.
	always @(posedge clk) begin
		if (!rst && mem_read1) begin
			if (!first_seen) begin
				check("mem_addr1", mem_addr1, lc3b_isa_pkg::pc_reset);
				first_seen = 1'b1;
			end
			if (mem_rdata1 != lc3b_isa_pkg::nop_instr) begin
				if (fetch_seen < exp_fetch.size()) begin
					check("mem_addr1", mem_addr1, exp_fetch[fetch_seen]);
				end else begin
					check("mem_addr1", mem_addr1, exp_fetch[exp_fetch.size() - 1]);
				end
				fetch_seen++;
			end
		end
		if (!rst && mem_read2) begin
			if (loads_seen < exp_load.size()) begin
				check("mem_addr2", mem_addr2, exp_load[loads_seen]);
				loads_seen++;
			end else begin
				fail_run("data read with mem_read2 that the model does not expect");
			end
		end
		if (!rst && mem_write2) begin
			if (stores_seen < exp_st_addr.size()) begin
				check("mem_addr2", mem_addr2, exp_st_addr[stores_seen]);
				check("mem_wdata2", mem_wdata2, exp_st_data[stores_seen]);
				stores_seen++;
			end else begin
				fail_run("data write with mem_write2 that the model does not expect");
			end
		end
	end

	initial begin
		lc3b_isa_pkg::lc3b_word w;
		for (int i = 0; i < mem_words; i++) begin
			w = 16'($random(seed));
			dmem[i] <= w;
			model_mem[i] = w;
			imem[i] = lc3b_isa_pkg::nop_instr;
		end
		gen_program();
		run_model();
		for (int i = 0; i < 5; i++) begin
			@(posedge clk);
			check("mem_read1", {15'b0, mem_read1}, 16'h0000);
			if (i > 0) begin
				check("mem_read2", {15'b0, mem_read2}, 16'h0000);
				check("mem_write2", {15'b0, mem_write2}, 16'h0000);
			end
		end
		rst <= 1'b0;
		cycles = 0;
		while ((fetch_seen < exp_fetch.size() || stores_seen < exp_st_addr.size())
			&& cycles < timeout_cycles) begin
			@(negedge clk);
			cycles++;
		end
		if (cycles >= timeout_cycles) begin
			fail_run("timeout before the program reached its final branch");
		end else begin
			repeat (10) @(negedge clk); // Stray strobes would show up here.
			if (loads_seen == exp_load.size() && stores_seen == exp_st_addr.size()) begin
				$display("Regression passed");
				$finish;
			end else begin
				fail_run("load or store count differs from the model");
			end
		end
	end

endmodule : tb_cpu_datapath

//--- writeback_module.sv
`timescale 1ns/100ps

module writeback_module
(
	input logic clk,
	input logic rst,
	input lc3b_pipe_pkg::mem_wb_t mem_wb,
	output logic reg_we,
	output lc3b_isa_pkg::lc3b_reg reg_waddr,
	output lc3b_isa_pkg::lc3b_word reg_wdata,
	output logic branch_enable,
	output lc3b_isa_pkg::lc3b_word br_target
);

	lc3b_isa_pkg::lc3b_nzp cc;
	lc3b_isa_pkg::lc3b_word result;

	function automatic lc3b_isa_pkg::lc3b_nzp gen_cc(input lc3b_isa_pkg::lc3b_word val);
		if (val[15]) begin
			return 3'b100;
		end else if (val == '0) begin
			return 3'b010;
		end
		return 3'b001;
	endfunction

	assign result = mem_wb.control.wb_from_mem ? mem_wb.load_data : mem_wb.alu_result;

	assign reg_we = mem_wb.valid && mem_wb.control.reg_load;
	assign reg_waddr = mem_wb.control.dest;
	assign reg_wdata = result;

	always_ff @(posedge clk) begin
		if (rst) begin
			cc <= '0;
		end else if (mem_wb.valid && mem_wb.control.set_cc) begin
			cc <= gen_cc(result);
		end
	end

	// Taken when mask and current flags overlap.
	assign branch_enable = mem_wb.valid && mem_wb.control.is_branch &&
		|(mem_wb.control.nzp & cc);
	assign br_target = mem_wb.br_target;

endmodule : writeback_module
